// File: hdl/iplru_pkg.sv
// Shared definitions for the instruction micro-TLB PLRU unit
// Entry count, index width, tree size and the vector types

package iplru_pkg;

  //----------------------------------------------------------------------
  // Sizes
  //----------------------------------------------------------------------
  // Micro-TLB entries
  localparam int ENTRY_NUM = 32;

  // Bits needed to name one entry
  localparam int IDX_W = 5;

  // Binary tree over the entries has one node less than leaves
  localparam int NODE_NUM = ENTRY_NUM - 1;

  //----------------------------------------------------------------------
  // Types
  //----------------------------------------------------------------------
  // One bit per entry
  typedef logic [ENTRY_NUM-1:0] entry_vec_t;

  // Entry number
  typedef logic [IDX_W-1:0] entry_idx_t;

  // Node bits in heap order
  // Node 0 is the root, node n has children 2n+1 and 2n+2
  typedef logic [NODE_NUM-1:0] tree_t;

  //----------------------------------------------------------------------
  // Constants
  //----------------------------------------------------------------------
  // Index reported when the hit vector is zero or has several bits set
  localparam entry_idx_t HIT_MISS_IDX = entry_idx_t'(16);

endpackage

// File: hdl/iplru_hit_decode.sv
// Hit decoding for the PLRU unit
// Encodes the one-hot hit vector, tracks the last hit entry and
// raises a tree update only when a new entry is hit

`timescale 1ns/1ps

module iplru_hit_decode
  import iplru_pkg::*;
(
  input  logic       lru_clk,
  input  logic       cpurst_b,
  input  entry_vec_t read_hit,
  input  logic       read_hit_vld,
  output entry_idx_t hit_idx,
  output logic       hit_updt
);

  entry_idx_t enc_idx;
  logic       hit_onehot;
  entry_idx_t hit_last;

  //----------------------------------------------------------------------
  // One-hot to index
  //----------------------------------------------------------------------
  // ORing the set positions is exact only for a single set bit
  always_comb
  begin
    enc_idx = '0;
    for (int i = 0; i < ENTRY_NUM; i++)
    begin
      if (read_hit[i])
        enc_idx = enc_idx | entry_idx_t'(i);
    end
  end

  // Exactly one bit set
  assign hit_onehot = (read_hit != '0)
                   && ((read_hit & (read_hit - 1'b1)) == '0);

  assign hit_idx = hit_onehot ? enc_idx : HIT_MISS_IDX;

  //----------------------------------------------------------------------
  // Last hit
  //----------------------------------------------------------------------
  always_ff @(posedge lru_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      hit_last <= '0;
    else if (read_hit_vld)
      hit_last <= hit_idx;
  end

  // Repeated hits to the same entry leave the tree alone
  assign hit_updt = read_hit_vld && (hit_idx != hit_last);

endmodule

// File: hdl/iplru_tree.sv
// PLRU tree for the instruction micro-TLB
// Holds the 31 node bits, applies refill and hit updates along the
// accessed path and walks the tree to find the victim entry

`timescale 1ns/1ps

module iplru_tree
  import iplru_pkg::*;
(
  input  logic       lru_clk,
  input  logic       cpurst_b,
  input  logic       refill_vld,
  input  entry_idx_t refill_idx,
  input  logic       hit_updt,
  input  entry_idx_t hit_idx,
  output entry_idx_t victim_idx
);

  //----------------------------------------------------------------------
  // Tree layout
  //----------------------------------------------------------------------
  //                        n0
  //               0 /              \ 1
  //             n1                    n2
  //          0 /  \ 1             0 /  \ 1
  //          n3    n4              n5    n6
  //         ....  ....            ....  ....
  //        n15 .............................. n30
  //       /   \                              /   \
  //     e0     e1                          e30    e31
  //
  // Level L holds nodes (2^L - 1) to (2^(L+1) - 2)
  // Index bit (IDX_W-1-L) picks the branch taken below level L

  tree_t tree_q;
  tree_t tree_nxt;
  tree_t refill_path;
  tree_t refill_val;
  tree_t hit_path;
  tree_t hit_val;
  tree_t refill_sel;
  tree_t hit_sel;

  // Position inside a level of the node that an index passes through
  function automatic int path_pos(entry_idx_t idx, int lvl);
    return int'(idx) >> (IDX_W - lvl);
  endfunction

  //----------------------------------------------------------------------
  // Path decode
  //----------------------------------------------------------------------
  // Node value points away from the accessed side
  always_comb
  begin
    refill_path = '0;
    refill_val  = '0;
    hit_path    = '0;
    hit_val     = '0;
    for (int lvl = 0; lvl < IDX_W; lvl++)
    begin
      for (int pos = 0; pos < (1 << lvl); pos++)
      begin
        refill_path[(1 << lvl) - 1 + pos] = (path_pos(refill_idx, lvl) == pos);
        refill_val[(1 << lvl) - 1 + pos]  = ~refill_idx[IDX_W - 1 - lvl];
        hit_path[(1 << lvl) - 1 + pos]    = (path_pos(hit_idx, lvl) == pos);
        hit_val[(1 << lvl) - 1 + pos]     = ~hit_idx[IDX_W - 1 - lvl];
      end
    end
  end

  //----------------------------------------------------------------------
  // Node update
  //----------------------------------------------------------------------
  // Refill owns every node on its path, hit takes the rest of its own
  assign refill_sel = refill_path & {NODE_NUM{refill_vld}};
  assign hit_sel    = hit_path & {NODE_NUM{hit_updt}} & ~refill_sel;

  assign tree_nxt = (refill_sel & refill_val)
                  | (hit_sel & hit_val)
                  | (tree_q & ~(refill_sel | hit_sel));

  always_ff @(posedge lru_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      tree_q <= '0;
    else
      tree_q <= tree_nxt;
  end

  //----------------------------------------------------------------------
  // Victim walk
  //----------------------------------------------------------------------
  // Right child when the node bit is set
  always_comb
  begin
    int node;
    node = 0;
    victim_idx = '0;
    for (int lvl = 0; lvl < IDX_W; lvl++)
    begin
      victim_idx[IDX_W - 1 - lvl] = tree_q[node];
      node = 2 * node + 1 + int'(tree_q[node]);
    end
  end

endmodule

// File: hdl/iplru_refill_select.sv
// Refill entry selection
// Picks the lowest invalid entry, or the tree victim once every
// entry is valid, and holds the choice as a one-hot refill vector

`timescale 1ns/1ps

module iplru_refill_select
  import iplru_pkg::*;
(
  input  logic       lru_clk,
  input  logic       cpurst_b,
  input  entry_vec_t entry_vld,
  input  logic       refill_on,
  input  entry_idx_t victim_idx,
  output entry_idx_t refill_idx,
  output entry_vec_t ref_num
);

  entry_idx_t free_idx;
  logic       all_vld;
  entry_idx_t refill_choice;

  //----------------------------------------------------------------------
  // Lowest invalid entry
  //----------------------------------------------------------------------
  // Scan downward so the lowest free slot is the last one written
  always_comb
  begin
    free_idx = '0;
    for (int i = ENTRY_NUM - 1; i >= 0; i--)
    begin
      if (!entry_vld[i])
        free_idx = entry_idx_t'(i);
    end
  end

  assign all_vld = &entry_vld;

  // Tree only decides when the TLB is full
  assign refill_choice = all_vld ? victim_idx : free_idx;

  //----------------------------------------------------------------------
  // Refill register
  //----------------------------------------------------------------------
  always_ff @(posedge lru_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      refill_idx <= '0;
    else if (refill_on)
      refill_idx <= refill_choice;
  end

  // One-hot view for the micro-TLB write enables
  assign ref_num = entry_vec_t'(1) << refill_idx;

endmodule

// File: hdl/iplru_top.sv
// Tree pseudo-LRU replacement unit for a 32-entry instruction
// micro-TLB
// Hit decode feeds the tree, the tree feeds refill selection

`timescale 1ns/1ps

module iplru_top
  import iplru_pkg::*;
(
  input  logic       lru_clk,
  input  logic       cpurst_b,
  input  entry_vec_t entry_vld,
  input  entry_vec_t read_hit,
  input  logic       read_hit_vld,
  input  logic       refill_on,
  input  logic       refill_vld,
  output entry_vec_t ref_num
);

  entry_idx_t hit_idx;
  logic       hit_updt;
  entry_idx_t victim_idx;
  entry_idx_t refill_idx;

  //----------------------------------------------------------------------
  // Hit decode
  //----------------------------------------------------------------------
  iplru_hit_decode u_hit_decode (
    .lru_clk      (lru_clk),
    .cpurst_b     (cpurst_b),
    .read_hit     (read_hit),
    .read_hit_vld (read_hit_vld),
    .hit_idx      (hit_idx),
    .hit_updt     (hit_updt)
  );

  //----------------------------------------------------------------------
  // PLRU tree
  //----------------------------------------------------------------------
  // Refill updates use the registered refill index
  iplru_tree u_tree (
    .lru_clk    (lru_clk),
    .cpurst_b   (cpurst_b),
    .refill_vld (refill_vld),
    .refill_idx (refill_idx),
    .hit_updt   (hit_updt),
    .hit_idx    (hit_idx),
    .victim_idx (victim_idx)
  );

  //----------------------------------------------------------------------
  // Refill selection
  //----------------------------------------------------------------------
  iplru_refill_select u_refill_select (
    .lru_clk    (lru_clk),
    .cpurst_b   (cpurst_b),
    .entry_vld  (entry_vld),
    .refill_on  (refill_on),
    .victim_idx (victim_idx),
    .refill_idx (refill_idx),
    .ref_num    (ref_num)
  );

endmodule

// File: dv/iplru_checker.sv
// Checker for the PLRU replacement unit
// Keeps a model of the node tree, last hit and refill register,
// compares ref_num every cycle and reports per test

`timescale 1ns/1ps

module iplru_checker
  import iplru_pkg::*;
(
  input logic       lru_clk,
  input logic       cpurst_b,
  input entry_vec_t entry_vld,
  input entry_vec_t read_hit,
  input logic       read_hit_vld,
  input logic       refill_on,
  input logic       refill_vld,
  input entry_vec_t ref_num
);

  tree_t      m_tree;
  tree_t      m_tree_nxt;
  entry_idx_t m_last_hit;
  entry_idx_t m_refill_idx;
  entry_idx_t m_victim;
  entry_idx_t m_hit_idx;
  entry_vec_t exp_ref;

  string cur_name = "reset";
  int    test_err = 0;
  int    test_cycles = 0;
  int    test_cnt = 0;
  int    test_fail = 0;
  int    err_total = 0;
  int    cmp_total = 0;

  //----------------------------------------------------------------------
  // Model helpers
  //----------------------------------------------------------------------
  // Hit vector with anything but one set bit maps to the miss index
  function automatic entry_idx_t model_hit_idx(entry_vec_t v);
    int         cnt;
    entry_idx_t pos;
    cnt = 0;
    pos = '0;
    for (int i = 0; i < ENTRY_NUM; i++)
    begin
      if (v[i])
      begin
        cnt++;
        pos = entry_idx_t'(i);
      end
    end
    return (cnt == 1) ? pos : HIT_MISS_IDX;
  endfunction

  function automatic entry_idx_t lowest_free(entry_vec_t v);
    for (int i = 0; i < ENTRY_NUM; i++)
    begin
      if (!v[i])
        return entry_idx_t'(i);
    end
    return '0;
  endfunction

  // Walk from the root and go right on a set node
  function automatic entry_idx_t model_victim(tree_t t);
    int         n;
    entry_idx_t idx;
    n = 0;
    idx = '0;
    for (int lvl = 0; lvl < IDX_W; lvl++)
    begin
      idx = {idx[IDX_W-2:0], t[n]};
      n = 2 * n + 1 + int'(t[n]);
    end
    return idx;
  endfunction

  // Every node on the path points away from the accessed side
  function automatic tree_t mark_path(tree_t t, entry_idx_t idx);
    tree_t r;
    int    n;
    logic  b;
    r = t;
    n = 0;
    for (int lvl = 0; lvl < IDX_W; lvl++)
    begin
      b = idx[IDX_W-1-lvl];
      r[n] = ~b;
      n = 2 * n + 1 + int'(b);
    end
    return r;
  endfunction

  //----------------------------------------------------------------------
  // Model state
  //----------------------------------------------------------------------
  always @(posedge lru_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      m_tree = '0;
      m_last_hit = '0;
      m_refill_idx = '0;
    end
    else
    begin
      m_victim = model_victim(m_tree);
      m_hit_idx = model_hit_idx(read_hit);
      m_tree_nxt = m_tree;
      if (read_hit_vld && (m_hit_idx != m_last_hit))
        m_tree_nxt = mark_path(m_tree_nxt, m_hit_idx);
      // Refill path written last so it owns shared nodes
      if (refill_vld)
        m_tree_nxt = mark_path(m_tree_nxt, m_refill_idx);
      if (read_hit_vld)
        m_last_hit = m_hit_idx;
      if (refill_on)
        m_refill_idx = (&entry_vld) ? m_victim : lowest_free(entry_vld);
      m_tree = m_tree_nxt;
    end
  end

  //----------------------------------------------------------------------
  // Comparison mid cycle once everything has settled
  //----------------------------------------------------------------------
  always @(negedge lru_clk)
  begin
    if (cpurst_b)
    begin
      for (int i = 0; i < ENTRY_NUM; i++)
      begin
        exp_ref[i] = (i == int'(m_refill_idx));
      end
      test_cycles++;
      cmp_total++;
      if (ref_num !== exp_ref)
      begin
        test_err++;
        err_total++;
        $display("[ERROR] %s: ref_num expected %h, actual %h", cur_name, exp_ref, ref_num);
      end
    end
  end

  //----------------------------------------------------------------------
  // Reporting
  //----------------------------------------------------------------------
  task automatic begin_test(input string name);
    cur_name = name;
    test_err = 0;
    test_cycles = 0;
  endtask

  task automatic end_test();
    test_cnt++;
    if (test_err != 0)
      test_fail++;
    $display("test %-12s %5d cycles, %0d mismatches, %s", cur_name, test_cycles,
             test_err, (test_err == 0) ? "pass" : "fail");
  endtask

  task automatic print_totals();
    $display("totals: %0d tests, %0d failed, %0d mismatches in %0d compared cycles",
             test_cnt, test_fail, err_total, cmp_total);
  endtask

endmodule

// File: dv/tb_top.sv
// Testbench top for the PLRU replacement unit
// Clock, reset, LFSR driven stimulus, DUT, checker and watchdog

`timescale 1ns/1ps

module tb_top;
  import iplru_pkg::*;

  localparam int CLK_PERIOD = 20;
  localparam int RESET_CYC  = 10;
  localparam int DRIVE_DLY  = 2;

  // Stimulus kinds
  localparam int K_IDLE = 0;
  localparam int K_FREE = 1;
  localparam int K_FULL = 2;
  localparam int K_HIT  = 3;
  localparam int K_DUAL = 4;
  localparam int K_MIX  = 5;

  // Test lengths in cycles
  localparam int LEN_IDLE = 40;
  localparam int LEN_FREE = 200;
  localparam int LEN_FULL = 200;
  localparam int LEN_HIT  = 200;
  localparam int LEN_DUAL = 200;
  localparam int LEN_MIX  = 2000;
  localparam int TOTAL_CYC = LEN_IDLE + LEN_FREE + LEN_FULL + LEN_HIT + LEN_DUAL + LEN_MIX;
  localparam int WATCHDOG_NS = 2 * TOTAL_CYC * CLK_PERIOD;

  logic        lru_clk;
  logic        cpurst_b;
  entry_vec_t  entry_vld;
  entry_vec_t  read_hit;
  logic        read_hit_vld;
  logic        refill_on;
  logic        refill_vld;
  entry_vec_t  ref_num;

  logic [31:0] lfsr_state = 32'hc37b_fbbc;
  entry_idx_t  hit_pick;

  iplru_top u_dut (
    .lru_clk      (lru_clk),
    .cpurst_b     (cpurst_b),
    .entry_vld    (entry_vld),
    .read_hit     (read_hit),
    .read_hit_vld (read_hit_vld),
    .refill_on    (refill_on),
    .refill_vld   (refill_vld),
    .ref_num      (ref_num)
  );

  iplru_checker u_checker (
    .lru_clk      (lru_clk),
    .cpurst_b     (cpurst_b),
    .entry_vld    (entry_vld),
    .read_hit     (read_hit),
    .read_hit_vld (read_hit_vld),
    .refill_on    (refill_on),
    .refill_vld   (refill_vld),
    .ref_num      (ref_num)
  );

  initial
    lru_clk = 1'b0;

  always #(CLK_PERIOD / 2) lru_clk = ~lru_clk;

  //----------------------------------------------------------------------
  // Random source
  //----------------------------------------------------------------------
  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      val = {val[30:0], lfsr_state[0]};
    end
  endtask

  //----------------------------------------------------------------------
  // Stimulus
  //----------------------------------------------------------------------
  task automatic gen_stimulus(input int kind, input int cyc);
    logic [31:0] r;
    logic [31:0] s;
    entry_vld = '1;
    read_hit = '0;
    read_hit_vld = 1'b0;
    refill_on = 1'b0;
    refill_vld = 1'b0;
    case (kind)
      K_IDLE:
      begin
        take_bits(32, r);
        entry_vld = r;
      end
      K_FREE:
      begin
        // At least one hole so the tree is bypassed
        take_bits(32, r);
        take_bits(5, s);
        entry_vld = r & ~(entry_vec_t'(1) << s[4:0]);
        take_bits(1, s);
        refill_on = s[0];
      end
      K_FULL:
      begin
        refill_on = (cyc % 2 == 0);
        refill_vld = (cyc % 2 == 1);
      end
      K_HIT:
      begin
        // Keep the previous entry one time in four
        take_bits(2, s);
        if (s[1:0] != 2'b00)
        begin
          take_bits(5, r);
          hit_pick = r[4:0];
        end
        read_hit = entry_vec_t'(1) << hit_pick;
        take_bits(3, s);
        read_hit_vld = (s[2:0] != 3'b000);
        refill_on = (cyc % 4 == 3);
        // Refill writes between repeated hits expose a skipped update
        refill_vld = (cyc % 4 == 1);
      end
      K_DUAL:
      begin
        take_bits(5, r);
        read_hit = entry_vec_t'(1) << r[4:0];
        read_hit_vld = 1'b1;
        refill_on = 1'b1;
        refill_vld = 1'b1;
      end
      default:
      begin
        take_bits(32, r);
        take_bits(2, s);
        if (s[1:0] == 2'b00)
          entry_vld = r;
        take_bits(6, r);
        read_hit = r[5] ? (entry_vec_t'(1) << r[4:0]) : '0;
        take_bits(3, s);
        read_hit_vld = s[0];
        refill_on = s[1];
        refill_vld = s[2];
      end
    endcase
  endtask

  task automatic run_test(input string name, input int kind, input int cycles);
    u_checker.begin_test(name);
    for (int c = 0; c < cycles; c++)
    begin
      @(posedge lru_clk);
      #(DRIVE_DLY);
      gen_stimulus(kind, c);
    end
    // Let the last drive reach the comparison
    @(posedge lru_clk);
    @(negedge lru_clk);
    #1;
    u_checker.end_test();
  endtask

  //----------------------------------------------------------------------
  // Sequence
  //----------------------------------------------------------------------
  initial
  begin
    cpurst_b = 1'b0;
    entry_vld = '0;
    read_hit = '0;
    read_hit_vld = 1'b0;
    refill_on = 1'b0;
    refill_vld = 1'b0;
    hit_pick = '0;
    repeat (RESET_CYC) @(posedge lru_clk);
    #(DRIVE_DLY);
    cpurst_b = 1'b1;

    run_test("reset_idle", K_IDLE, LEN_IDLE);
    run_test("free_fill", K_FREE, LEN_FREE);
    run_test("full_refill", K_FULL, LEN_FULL);
    run_test("hit_walk", K_HIT, LEN_HIT);
    run_test("dual_update", K_DUAL, LEN_DUAL);
    run_test("random_mix", K_MIX, LEN_MIX);

    u_checker.print_totals();
    if (u_checker.err_total == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

  // Watchdog
  initial
  begin
    #(WATCHDOG_NS);
    $display("Timeout: test sequence still running after %0d ns", WATCHDOG_NS);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

// File: iplru.f
hdl/iplru_pkg.sv
hdl/iplru_hit_decode.sv
hdl/iplru_tree.sv
hdl/iplru_refill_select.sv
hdl/iplru_top.sv
dv/iplru_checker.sv
dv/tb_top.sv

// File: Makefile
SIM       := verilator
SIM_FLAGS := --binary --timing -Wno-fatal -j 0
TOP       := tb_top
FILELIST  := iplru.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := ERRORS FOUND
PASS_MSG  := NO ERRORS

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "simulation did not complete, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
